// ==== hw/mem_pkg.sv ====
// shared sizes and types of the memory subsystem
// the RAM is byte addressed, and the APB window starts at address zero
package mem_pkg;

    // byte address width of the RAM (4 KiB)
    localparam int MEM_ADDR_W = 12;

    // a fetch line is sixteen bytes, read as one 128-bit word
    localparam int LINE_BYTES = 16;
    localparam int LINE_W = 8 * LINE_BYTES;
    localparam int LINE_OFF_W = $clog2(LINE_BYTES);

    // full APB address; everything at or above 2**MEM_ADDR_W is out of range
    localparam int APB_ADDR_W = 32;

    // one data word seen either whole (APB side) or as four byte lanes (RAM side)
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] bytes;
    } data_word_u;

endpackage

// ==== hw/ram_data_if.sv ====
// 32-bit data port of the RAM. An access is a cycle with en high
// read data follows one clock later, and writes land on the same edge for enabled bytes
`timescale 1ns/100ps

interface ram_data_if;

    logic                            en;
    logic [mem_pkg::MEM_ADDR_W-1:0]  addr;
    mem_pkg::data_word_u             wdata;
    logic                            we;
    logic [3:0]                      be;
    mem_pkg::data_word_u             rdata;

    modport requester (
        output en, addr, wdata, we, be,
        input  rdata
    );

    modport ram (
        input  en, addr, wdata, we, be,
        output rdata
    );

    // the fetch buffer only watches for writes into its line
    modport snoop (
        input en, addr, we
    );

endinterface

// ==== hw/dp_ram.sv ====
// byte-organised dual-port RAM with no reset on the array
// the line port reads sixteen bytes from the line address, which should be line aligned
`timescale 1ns/100ps

module dp_ram #(
    parameter int ADDR_WIDTH = mem_pkg::MEM_ADDR_W
) (
    input  logic                           clk_i,

    // line read port
    input  logic [mem_pkg::MEM_ADDR_W-1:0] line_addr_i,
    output logic [mem_pkg::LINE_W-1:0]     line_o,

    // 32-bit byte-enabled data port
    ram_data_if.ram                        data_if
);

    logic [7:0]            mem [2**ADDR_WIDTH];

    logic [ADDR_WIDTH-1:0] line_base;
    logic [ADDR_WIDTH-1:0] data_full;
    logic [ADDR_WIDTH-1:0] data_base;
    mem_pkg::data_word_u   rdata_q;

    always_comb begin
        line_base = ADDR_WIDTH'(line_addr_i);
        data_full = ADDR_WIDTH'(data_if.addr);
        // the data port ignores the low address bits and always works on a whole word
        data_base = {data_full[ADDR_WIDTH-1:2], 2'b00};
    end

    // the line port reads every cycle, whatever the data port does
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < mem_pkg::LINE_BYTES; i++) begin
            line_o[8*i +: 8] <= mem[line_base + ADDR_WIDTH'(i)];
        end
    end

    always_ff @(posedge clk_i) begin
        if (data_if.en) begin
            if (data_if.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (data_if.be[b]) begin
                        mem[data_base + ADDR_WIDTH'(b)] <= data_if.wdata.bytes[b];
                    end
                end
            end else begin
                // a read returns all four bytes, the byte enables are not used here
                for (int b = 0; b < 4; b++) begin
                    rdata_q.bytes[b] <= mem[data_base + ADDR_WIDTH'(b)];
                end
            end
        end
    end

    assign data_if.rdata = rdata_q;

endmodule

// ==== hw/apb_data_port.sv ====
// APB slave on the RAM data port. Writes take no wait state, reads take one
// addresses at or above 2**MEM_ADDR_W end at once with pslverr and never reach the RAM
`timescale 1ns/100ps

module apb_data_port (
    input  logic                           clk_i,
    input  logic                           arst_n_i,

    input  logic                           psel_i,
    input  logic                           penable_i,
    input  logic                           pwrite_i,
    input  logic [mem_pkg::APB_ADDR_W-1:0] paddr_i,
    input  logic [31:0]                    pwdata_i,
    input  logic [3:0]                     pstrb_i,
    output logic [31:0]                    prdata_o,
    output logic                           pready_o,
    output logic                           pslverr_o,

    ram_data_if.requester                  ram_if
);

    logic                in_range;
    logic                first_acc;
    logic                rd_pend_q;
    mem_pkg::data_word_u wdata_w;

    // only the lowest MEM_ADDR_W bits may be set for a valid access
    assign in_range = (paddr_i[mem_pkg::APB_ADDR_W-1:mem_pkg::MEM_ADDR_W] == '0);

    // rd_pend_q marks the second access cycle of a read, so it blocks a second issue
    assign first_acc = psel_i && penable_i && !rd_pend_q;

    always_comb begin
        wdata_w.word = pwdata_i;
        ram_if.en    = first_acc && in_range;
        ram_if.addr  = paddr_i[mem_pkg::MEM_ADDR_W-1:0];
        ram_if.wdata = wdata_w;
        ram_if.we    = pwrite_i;
        ram_if.be    = pstrb_i;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_pend_q <= 1'b0;
        end else begin
            rd_pend_q <= first_acc && in_range && !pwrite_i;
        end
    end

    // a write or an error finishes in the first access cycle, a read one cycle later
    assign pready_o  = (first_acc && (pwrite_i || !in_range)) || rd_pend_q;
    assign pslverr_o = first_acc && !in_range;

    // RAM read data is only passed on in the cycle it is valid, so errors return zero
    assign prdata_o  = rd_pend_q ? ram_if.rdata.word : 32'h0;

endmodule

// ==== hw/fetch_buffer.sv ====
// one-line instruction buffer. The requester holds fetch_req_i and fetch_addr_i
// until fetch_valid_o; a hit answers after one cycle and a miss after two
`timescale 1ns/100ps

module fetch_buffer (
    input  logic                           clk_i,
    input  logic                           arst_n_i,

    input  logic                           fetch_req_i,
    input  logic [mem_pkg::MEM_ADDR_W-1:0] fetch_addr_i,
    output logic [31:0]                    fetch_instr_o,
    output logic                           fetch_valid_o,

    // line port of the RAM, the line arrives one cycle after the address
    output logic [mem_pkg::MEM_ADDR_W-1:0] line_addr_o,
    input  logic [mem_pkg::LINE_W-1:0]     line_i,

    ram_data_if.snoop                      snoop_if
);

    logic [mem_pkg::LINE_W-1:0]                         line_q;
    logic [mem_pkg::MEM_ADDR_W-1:mem_pkg::LINE_OFF_W]   tag_q;
    logic                                               line_vld_q;
    logic                                               fill_q;
    logic                                               stale_q;

    logic [mem_pkg::MEM_ADDR_W-1:mem_pkg::LINE_OFF_W]   req_tag;
    logic [mem_pkg::MEM_ADDR_W-1:mem_pkg::LINE_OFF_W]   snoop_tag;
    logic [mem_pkg::LINE_OFF_W-3:0]                     word_sel;
    logic                                               snoop_wr;
    logic                                               snoop_buf;
    logic                                               snoop_req;
    logic                                               hit;
    logic                                               start;
    logic                                               fill_done;
    logic [mem_pkg::LINE_W-1:0]                         sel_line;

    assign req_tag   = fetch_addr_i[mem_pkg::MEM_ADDR_W-1:mem_pkg::LINE_OFF_W];
    assign word_sel  = fetch_addr_i[mem_pkg::LINE_OFF_W-1:2];
    assign snoop_tag = snoop_if.addr[mem_pkg::MEM_ADDR_W-1:mem_pkg::LINE_OFF_W];

    // the RAM line address always follows the request, aligned to the line
    assign line_addr_o = {req_tag, {mem_pkg::LINE_OFF_W{1'b0}}};

    assign snoop_wr  = snoop_if.en && snoop_if.we;
    assign snoop_buf = snoop_wr && (snoop_tag == tag_q);
    assign snoop_req = snoop_wr && (snoop_tag == req_tag);

    // a write into the buffered line in this cycle turns a hit into a miss
    assign hit   = line_vld_q && (tag_q == req_tag) && !snoop_buf;
    // fetch_req_i is still high in the fetch_valid_o cycle, so that cycle is skipped
    assign start = fetch_req_i && !fill_q && !fetch_valid_o;

    // line_i misses a write that landed on the edge it was read, so such a fill repeats
    assign fill_done = fill_q && !stale_q;

    assign sel_line = fill_q ? line_i : line_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fill_q        <= 1'b0;
            stale_q       <= 1'b0;
            line_vld_q    <= 1'b0;
            fetch_valid_o <= 1'b0;
        end else begin
            fetch_valid_o <= 1'b0;
            stale_q       <= snoop_req;
            if (snoop_buf) begin
                line_vld_q <= 1'b0;
            end
            if (fill_done) begin
                fill_q        <= 1'b0;
                line_vld_q    <= !snoop_req;
                fetch_valid_o <= 1'b1;
            end else if (start) begin
                if (hit) begin
                    fetch_valid_o <= 1'b1;
                end else begin
                    fill_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_done) begin
            line_q <= line_i;
            tag_q  <= req_tag;
        end
        if (fill_done || (start && hit)) begin
            fetch_instr_o <= sel_line[32*word_sel +: 32];
        end
    end

endmodule

// ==== hw/mem_subsys_top.sv ====
// memory subsystem with an APB data port and a line-buffered instruction fetch port
// APB addresses at or above 2**MEM_ADDR_W return pslverr
`timescale 1ns/100ps

module mem_subsys_top (
    input  logic                           clk_i,
    input  logic                           arst_n_i,

    // APB slave
    input  logic                           psel_i,
    input  logic                           penable_i,
    input  logic                           pwrite_i,
    input  logic [mem_pkg::APB_ADDR_W-1:0] paddr_i,
    input  logic [31:0]                    pwdata_i,
    input  logic [3:0]                     pstrb_i,
    output logic [31:0]                    prdata_o,
    output logic                           pready_o,
    output logic                           pslverr_o,

    // instruction fetch
    input  logic                           fetch_req_i,
    input  logic [mem_pkg::MEM_ADDR_W-1:0] fetch_addr_i,
    output logic [31:0]                    fetch_instr_o,
    output logic                           fetch_valid_o
);

    logic [mem_pkg::MEM_ADDR_W-1:0] line_addr;
    logic [mem_pkg::LINE_W-1:0]     line;

    ram_data_if data_if ();

    apb_data_port u_apb_data_port (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .pstrb_i   (pstrb_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .ram_if    (data_if.requester)
    );

    fetch_buffer u_fetch_buffer (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .fetch_req_i   (fetch_req_i),
        .fetch_addr_i  (fetch_addr_i),
        .fetch_instr_o (fetch_instr_o),
        .fetch_valid_o (fetch_valid_o),
        .line_addr_o   (line_addr),
        .line_i        (line),
        .snoop_if      (data_if.snoop)
    );

    dp_ram #(
        .ADDR_WIDTH (mem_pkg::MEM_ADDR_W)
    ) u_dp_ram (
        .clk_i       (clk_i),
        .line_addr_i (line_addr),
        .line_o      (line),
        .data_if     (data_if.ram)
    );

endmodule

// ==== verification/mem_subsys_asserts.sv ====
// protocol assertions on the top-level ports of mem_subsys_top, bound from the testbench
// checks are off while arst_n_i is low
`timescale 1ns/100ps

module mem_subsys_asserts (
    input logic clk_i,
    input logic arst_n_i,
    input logic psel_i,
    input logic penable_i,
    input logic pready_o,
    input logic pslverr_o,
    input logic fetch_req_i,
    input logic fetch_valid_o
);

    // pready may only end an access phase
    a_pready_in_access: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        pready_o |-> (psel_i && penable_i))
        else $error("pready_o high outside an APB access phase");

    a_pslverr_with_pready: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        pslverr_o |-> pready_o)
        else $error("pslverr_o high without pready_o");

    // fetch_valid_o is a single-cycle pulse
    a_fetch_valid_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        fetch_valid_o |=> !fetch_valid_o)
        else $error("fetch_valid_o high for two cycles in a row");

    a_fetch_valid_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        fetch_valid_o |-> fetch_req_i)
        else $error("fetch_valid_o high without a pending fetch_req_i");

endmodule

// ==== verification/mem_subsys_tb.sv ====
// directed testbench for mem_subsys_top. RAM words are only read back after the testbench
// wrote them, because the RAM array has no reset
`timescale 1ns/100ps

module mem_subsys_tb;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_TESTS  = 6;
    localparam int WAIT_LIMIT = 10;
    localparam int RAM_BYTES  = 2 ** mem_pkg::MEM_ADDR_W;
    localparam logic [mem_pkg::MEM_ADDR_W-1:0] LINE_BASE = 12'h400;

    logic                           clk_i;
    logic                           arst_n_i;
    logic                           psel_i;
    logic                           penable_i;
    logic                           pwrite_i;
    logic [mem_pkg::APB_ADDR_W-1:0] paddr_i;
    logic [31:0]                    pwdata_i;
    logic [3:0]                     pstrb_i;
    logic [31:0]                    prdata_o;
    logic                           pready_o;
    logic                           pslverr_o;
    logic                           fetch_req_i;
    logic [mem_pkg::MEM_ADDR_W-1:0] fetch_addr_i;
    logic [31:0]                    fetch_instr_o;
    logic                           fetch_valid_o;

    // expected RAM contents, updated by every in-range APB write
    logic [7:0] sb [RAM_BYTES];
    int         errors;
    int         checks;

    mem_subsys_top UUT (.*);

    bind mem_subsys_top mem_subsys_asserts u_asserts (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("ERROR: watchdog expired, the tests did not finish in time");
        $display("Test failed");
        $finish;
    end

    task automatic check_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            $display("CHECK FAILED at %0d ns: %s expected %h, actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        int base;
        base = int'({addr[mem_pkg::MEM_ADDR_W-1:2], 2'b00});
        return {sb[base + 3], sb[base + 2], sb[base + 1], sb[base]};
    endfunction

    // setup phase now, then access cycles until pready; starts and ends 2 ns after an edge
    task automatic apb_transfer(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                                input logic [3:0] strb, output logic [31:0] rdata,
                                output logic err);
        int waited;
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = wr;
        paddr_i   = addr;
        pwdata_i  = data;
        pstrb_i   = strb;
        @(posedge clk_i);
        #2;
        penable_i = 1'b1;
        @(negedge clk_i);
        waited = 1;
        while (!pready_o && waited < WAIT_LIMIT) begin
            @(negedge clk_i);
            waited++;
        end
        if (!pready_o) begin
            $display("ERROR: APB transfer to address %h never got pready", addr);
            errors++;
        end
        rdata = prdata_o;
        err   = pslverr_o;
        @(posedge clk_i);
        #2;
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output logic err);
        logic [31:0] unused_rdata;
        int          base;
        apb_transfer(1'b1, addr, data, strb, unused_rdata, err);
        if (addr < RAM_BYTES) begin
            base = int'({addr[mem_pkg::MEM_ADDR_W-1:2], 2'b00});
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    sb[base + b] = data[8*b +: 8];
                end
            end
        end
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] data, output logic err);
        apb_transfer(1'b0, addr, 32'h0, 4'h0, data, err);
    endtask

    task automatic fetch(input logic [mem_pkg::MEM_ADDR_W-1:0] addr, output logic [31:0] instr,
                         output int cycles);
        fetch_req_i  = 1'b1;
        fetch_addr_i = addr;
        @(negedge clk_i);
        cycles = 1;
        while (!fetch_valid_o && cycles < WAIT_LIMIT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!fetch_valid_o) begin
            $display("ERROR: fetch of address %h never got fetch_valid_o", addr);
            errors++;
        end
        instr = fetch_instr_o;
        @(posedge clk_i);
        #2;
        fetch_req_i = 1'b0;
    endtask

    task automatic reset_outputs_low();
        check_equal("pready_o", 32'd0, {31'd0, pready_o});
        check_equal("pslverr_o", 32'd0, {31'd0, pslverr_o});
        check_equal("prdata_o", 32'd0, prdata_o);
        check_equal("fetch_valid_o", 32'd0, {31'd0, fetch_valid_o});
    endtask

    task automatic word_write_read();
        logic [31:0] addrs [8];
        logic [31:0] data;
        logic        err;
        for (int i = 0; i < 8; i++) begin
            addrs[i] = $urandom & 32'h0000_0ffc;
            apb_write(addrs[i], $urandom, 4'hf, err);
            check_equal("pslverr_o", 32'd0, {31'd0, err});
        end
        for (int i = 0; i < 8; i++) begin
            apb_read(addrs[i], data, err);
            check_equal("prdata_o", expected_word(addrs[i]), data);
            check_equal("pslverr_o", 32'd0, {31'd0, err});
        end
    endtask

    task automatic partial_strobe_write();
        logic [3:0]  strbs [3];
        logic [31:0] data;
        logic        err;
        strbs = '{4'b0101, 4'b1000, 4'b0110};
        apb_write(32'h0000_0200, 32'h1122_3344, 4'hf, err);
        for (int i = 0; i < 3; i++) begin
            apb_write(32'h0000_0200, $urandom, strbs[i], err);
            apb_read(32'h0000_0200, data, err);
            check_equal("prdata_o", expected_word(32'h0000_0200), data);
        end
    endtask

    task automatic out_of_range_error();
        logic [31:0] data;
        logic        err;
        apb_write(32'h0000_0300, 32'hcafe_f00d, 4'hf, err);
        // the low twelve bits alias the word above, which must stay untouched
        apb_write(32'h0000_1300, 32'hdead_beef, 4'hf, err);
        check_equal("pslverr_o", 32'd1, {31'd0, err});
        apb_read(32'h0000_1300, data, err);
        check_equal("pslverr_o", 32'd1, {31'd0, err});
        check_equal("prdata_o", 32'd0, data);
        apb_read(32'hffff_fffc, data, err);
        check_equal("pslverr_o", 32'd1, {31'd0, err});
        check_equal("prdata_o", 32'd0, data);
        apb_read(32'h0000_0300, data, err);
        check_equal("pslverr_o", 32'd0, {31'd0, err});
        check_equal("prdata_o", expected_word(32'h0000_0300), data);
    endtask

    task automatic line_fetch_words();
        logic [31:0] instr;
        logic        err;
        int          cycles [4];
        logic        first_slowest;
        for (int i = 0; i < 4; i++) begin
            apb_write(32'(LINE_BASE) + 32'(4 * i), $urandom, 4'hf, err);
        end
        for (int i = 0; i < 4; i++) begin
            fetch(LINE_BASE + 12'(4 * i), instr, cycles[i]);
            check_equal("fetch_instr_o", expected_word(32'(LINE_BASE) + 32'(4 * i)), instr);
        end
        first_slowest = (cycles[0] > cycles[1]) && (cycles[0] > cycles[2])
                        && (cycles[0] > cycles[3]);
        check_equal("first fetch slowest", 32'd1, {31'd0, first_slowest});
    endtask

    task automatic snoop_invalidates_line();
        logic [31:0] instr;
        logic        err;
        int          cycles;
        fetch(LINE_BASE + 12'h8, instr, cycles);
        check_equal("fetch_instr_o", expected_word(32'(LINE_BASE) + 32'h8), instr);
        apb_write(32'(LINE_BASE) + 32'h8, $urandom, 4'hf, err);
        fetch(LINE_BASE + 12'h8, instr, cycles);
        check_equal("fetch_instr_o", expected_word(32'(LINE_BASE) + 32'h8), instr);
    endtask

    initial begin
        void'($urandom(32'h595d_4d55));
        errors       = 0;
        checks       = 0;
        arst_n_i     = 1'b0;
        psel_i       = 1'b0;
        penable_i    = 1'b0;
        pwrite_i     = 1'b0;
        paddr_i      = '0;
        pwdata_i     = '0;
        pstrb_i      = '0;
        fetch_req_i  = 1'b0;
        fetch_addr_i = '0;
        repeat (2) @(posedge clk_i);
        #2;
        arst_n_i = 1'b1;
        @(posedge clk_i);
        #2;
        reset_outputs_low();
        word_write_read();
        partial_strobe_write();
        out_of_range_error();
        line_fetch_words();
        snoop_invalidates_line();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
hw/mem_pkg.sv
hw/ram_data_if.sv
hw/dp_ram.sv
hw/apb_data_port.sv
hw/fetch_buffer.sv
hw/mem_subsys_top.sv
verification/mem_subsys_asserts.sv
verification/mem_subsys_tb.sv

// ==== Makefile ====
# Verilator build and run of the memory subsystem testbench
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -j 0
TOP       := mem_subsys_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
PASS_MSG  := Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  make test   build the testbench with Verilator and run it"
	@echo "  make clean  remove the Verilator build directory"
	@echo "  make help   show this list"

# the run passes only if the simulation prints the pass message on a line of its own
test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
